// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall
TOP       ?= tb_mycpu
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_mycpu.sv
`default_nettype none

`include "cpu_defines.svh"

module tb_mycpu;

    logic             clk;
    logic             reset;
    logic [31:0]      inst_sram_addr;
    logic [31:0]      inst_sram_rdata;
    logic             data_sram_en;
    logic             data_sram_we;
    logic [31:0]      data_sram_addr;
    logic [31:0]      data_sram_wdata;
    logic [31:0]      data_sram_rdata;
    core_pkg::trace_t debug_wb;

    logic [31:0] imem [1024];
    logic [31:0] dmem [256];
    logic [31:0] m_dmem [256];  // Model copy of the data memory.
    logic [31:0] m_regs [`CPU_NUM_REGS];
    logic [31:0] m_pc;
    logic [31:0] lfsr;
    int          n_instr;

    mycpu_top u_mycpu_top (
        .clk             (clk),
        .reset           (reset),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata),
        .debug_wb        (debug_wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Both memories answer on the falling edge, so data is steady for the next cycle.
    always @(negedge clk) begin
        inst_sram_rdata <= imem[10'((inst_sram_addr - `CPU_RESET_PC) >> 2)];
        if (data_sram_we) dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        if (data_sram_en) data_sram_rdata <= dmem[data_sram_addr[9:2]];
    end

    // ========================================
    // Stimulus helpers
    // ========================================

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};  // High offset bits sit at the bottom.
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[n_instr] = word;
        n_instr++;
    endtask

    task automatic end_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    // ========================================
    // Reference model
    // ========================================

    function automatic core_pkg::trace_t model_step();
        core_pkg::trace_t ev;
        logic [31:0] word, a, b, d, sext12, val, nxt, addr;
        logic [4:0]  rd, rj, rk;
        logic        wr;
        word   = imem[10'((m_pc - `CPU_RESET_PC) >> 2)];
        rd     = word[4:0];
        rj     = word[9:5];
        rk     = word[14:10];
        a      = m_regs[rj];
        b      = m_regs[rk];
        d      = m_regs[rd];
        sext12 = {{20{word[21]}}, word[21:10]};
        nxt    = m_pc + 32'd4;
        wr     = 1'b1;
        val    = '0;
        case (word[31:15])
            17'h00020: val = a + b;
            17'h00022: val = a - b;
            17'h00024: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            17'h00025: val = (a < b) ? 32'd1 : 32'd0;
            17'h00028: val = ~(a | b);
            17'h00029: val = a & b;
            17'h0002a: val = a | b;
            17'h0002b: val = a ^ b;
            17'h00081: val = a << rk;
            17'h00089: val = a >> rk;
            17'h00091: val = $signed(a) >>> rk;
            default: begin
                wr   = 1'b0;
                addr = a + sext12;
                if (word[31:22] == 10'h00a) begin
                    val = a + sext12;
                    wr  = 1'b1;
                end else if (word[31:25] == 7'h0a) begin
                    val = {word[24:5], 12'd0};
                    wr  = 1'b1;
                end else if (word[31:22] == 10'h0a2) begin
                    val = m_dmem[addr[9:2]];
                    wr  = 1'b1;
                end else if (word[31:22] == 10'h0a6) begin
                    m_dmem[addr[9:2]] = d;
                end else begin
                    case (word[31:26])
                        6'h13: begin
                            val = m_pc + 32'd4;
                            wr  = 1'b1;
                            nxt = a + {{14{word[25]}}, word[25:10], 2'b00};
                        end
                        6'h14: nxt = m_pc + {{4{word[9]}}, word[9:0], word[25:10], 2'b00};
                        6'h15: begin
                            val = m_pc + 32'd4;
                            wr  = 1'b1;
                            rd  = `CPU_LINK_REG;
                            nxt = m_pc + {{4{word[9]}}, word[9:0], word[25:10], 2'b00};
                        end
                        6'h16: if (a == d) nxt = m_pc + {{14{word[25]}}, word[25:10], 2'b00};
                        6'h17: if (a != d) nxt = m_pc + {{14{word[25]}}, word[25:10], 2'b00};
                        default: ;
                    endcase
                end
            end
        endcase
        ev = '{pc: m_pc, rf_we: 1'b0, rf_wnum: rd, rf_wdata: val};
        if (wr && (rd != 5'd0)) begin
            m_regs[rd] = val;
            ev.rf_we   = 1'b1;
        end
        m_pc = nxt;
        return ev;
    endfunction

    // ========================================
    // Program and checking
    // ========================================

    initial begin
        core_pkg::trace_t exp;
        logic [31:0] end_addr, base, off;
        logic [19:0] hi;
        int cycles, limit, steps, dut_events, model_events, n;
        bit done;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        lfsr            = 32'hdd13c07d;
        n_instr         = 0;
        for (int i = 0; i < 1024; i++) imem[i] = '0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]   = i * 32'h9e3779b9;
            m_dmem[i] = dmem[i];
        end
        for (int i = 0; i < `CPU_NUM_REGS; i++) m_regs[i] = '0;

        for (int r = 2; r < 10; r++) begin  // Random constants, r8 negative, r9 positive.
            hi = 20'(lfsr_bits(20));
            if (r == 8) hi[19:18] = 2'b11;
            if (r == 9) hi[19:18] = 2'b01;
            emit({7'h0a, hi, 5'(r)});
            emit({10'h00a, 12'(lfsr_bits(12)), 5'(r), 5'(r)});
        end
        for (int i = 0; i < 8; i++) begin
            emit({17'h00020 | 17'(i < 3 ? 2 * i : (i == 3 ? 5 : 4 + i)),
                  5'(2 + lfsr_bits(3)), 5'(2 + lfsr_bits(3)), 5'(10 + i)});
        end
        emit({17'h00024, 5'd9, 5'd8, 5'd18});  // slt and sltu across the sign bit.
        emit({17'h00025, 5'd9, 5'd8, 5'd19});
        emit({17'h00081, 5'(lfsr_bits(5)), 5'd8, 5'd15});
        emit({17'h00089, 5'(lfsr_bits(5)), 5'd8, 5'd16});
        emit({17'h00091, 5'(lfsr_bits(5)), 5'd8, 5'd17});
        for (int i = 0; i < 4; i++) begin
            base = lfsr_bits(7) << 2;
            off  = lfsr_bits(7) << 2;
            emit({10'h00a, base[11:0], 5'd0, 5'd20});
            emit({10'h0a6, off[11:0], 5'd20, 5'(2 + i)});
            emit({10'h0a2, off[11:0], 5'd20, 5'(21 + i)});
        end
        emit({6'h16, 16'd2, 5'd2, 5'd2});  // beq taken.
        emit({10'h00a, 12'd1, 5'd0, 5'd25});
        emit({10'h00a, 12'd2, 5'd0, 5'd25});
        emit({6'h16, 16'd2, 5'd2, 5'd3});  // beq not taken.
        emit({10'h00a, 12'd3, 5'd0, 5'd25});
        emit({6'h17, 16'd2, 5'd2, 5'd3});  // bne taken.
        emit({10'h00a, 12'd4, 5'd0, 5'd25});
        emit({10'h00a, 12'd5, 5'd0, 5'd25});
        emit({6'h17, 16'd2, 5'd2, 5'd2});  // bne not taken.
        emit({10'h00a, 12'd6, 5'd0, 5'd25});
        emit(enc_i26(6'h14, 26'd2));
        emit({10'h00a, 12'd7, 5'd0, 5'd25});
        emit({10'h00a, 12'd8, 5'd0, 5'd25});
        emit(enc_i26(6'h15, 26'd2));
        emit({10'h00a, 12'd9, 5'd0, 5'd25});
        emit({17'h00020, 5'd0, 5'd1, 5'd30});
        n = n_instr;  // r26 gets the jirl address, and jirl skips one word.
        emit({7'h0a, 20'h1c000, 5'd26});
        emit({10'h00a, 12'((n + 2) * 4), 5'd26, 5'd26});
        emit({6'h13, 16'd2, 5'd26, 5'd27});
        emit({10'h00a, 12'd10, 5'd0, 5'd28});
        emit({10'h00a, 12'd11, 5'd0, 5'd28});
        emit({17'h00020, 5'd3, 5'd2, 5'd0});
        emit({10'h00a, 12'd5, 5'd0, 5'd0});
        emit({17'h0002a, 5'd0, 5'd0, 5'd29});
        end_addr = `CPU_RESET_PC + 32'(n_instr * 4);
        emit(enc_i26(6'h14, 26'd0));  // Final loop.

        m_pc  = `CPU_RESET_PC;
        limit = n_instr * 5 + 50;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cycles       = 0;
        dut_events   = 0;
        model_events = 0;
        done         = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: the program did not reach its final loop in %0d cycles",
                         limit);
                end_with_failure();
            end
            if (debug_wb.rf_we) begin
                dut_events++;
                steps = 0;
                do begin
                    exp = model_step();
                    steps++;
                end while (!exp.rf_we && steps < limit);
                model_events++;
                assert (exp.rf_we) else begin
                    $display("DUT wrote a register that the model never writes");
                    end_with_failure();
                end
                assert (debug_wb.pc == exp.pc) else begin
                    $display("error at %0t: pc %h, expected %h", $time, debug_wb.pc, exp.pc);
                    end_with_failure();
                end
                assert (debug_wb.rf_wnum == exp.rf_wnum) else begin
                    $display("error at %0t: pc %h wnum %0d, expected %0d", $time,
                             exp.pc, debug_wb.rf_wnum, exp.rf_wnum);
                    end_with_failure();
                end
                assert (debug_wb.rf_wdata == exp.rf_wdata) else begin
                    $display("error at %0t: pc %h wdata %h, expected %h", $time,
                             exp.pc, debug_wb.rf_wdata, exp.rf_wdata);
                    end_with_failure();
                end
            end
            if (inst_sram_addr == end_addr) done = 1'b1;
        end
        // Any write still left in the model was missed by the DUT.
        steps = 0;
        while (m_pc != end_addr && steps < limit) begin
            exp = model_step();
            steps++;
            if (exp.rf_we) model_events++;
        end
        assert (dut_events == model_events) else begin
            $display("error at %0t: %0d trace events, expected %0d", $time,
                     dut_events, model_events);
            end_with_failure();
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/isa_pkg.sv
logic/core_pkg.sv
logic/inst_decoder.sv
logic/alu.sv
logic/regfile.sv
logic/mycpu_top.sv
dv/tb_mycpu.sv

// File: logic/alu.sv
`default_nettype none

module alu (
    input  isa_pkg::alu_op_e alu_op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    output logic [31:0]      result
);

    logic [4:0]  shamt;
    logic [32:0] diff;
    logic        lt_signed;
    logic        lt_unsigned;

    assign shamt = src2[4:0];

    // One subtractor serves sub, slt and sltu.
    assign diff        = {1'b0, src1} - {1'b0, src2};
    assign lt_unsigned = diff[32];
    assign lt_signed   = (src1[31] != src2[31]) ? src1[31] : diff[31];

    always_comb begin
        case (alu_op)
            isa_pkg::alu_add:  result = src1 + src2;
            isa_pkg::alu_sub:  result = diff[31:0];
            isa_pkg::alu_slt:  result = {31'd0, lt_signed};
            isa_pkg::alu_sltu: result = {31'd0, lt_unsigned};
            isa_pkg::alu_and:  result = src1 & src2;
            isa_pkg::alu_nor:  result = ~(src1 | src2);
            isa_pkg::alu_or:   result = src1 | src2;
            isa_pkg::alu_xor:  result = src1 ^ src2;
            isa_pkg::alu_sll:  result = src1 << shamt;
            isa_pkg::alu_srl:  result = src1 >> shamt;
            isa_pkg::alu_sra:  result = $signed(src1) >>> shamt;
            isa_pkg::alu_lui:  result = src2;  // Immediate is already shifted.
            default:           result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef enum logic [2:0] {
        s_if  = 3'd0,
        s_id  = 3'd1,
        s_exe = 3'd2,
        s_mem = 3'd3,
        s_wb  = 3'd4
    } state_e;

    // Decoded control for one instruction.
    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        logic             src1_is_pc;
        logic             src2_is_imm;
        logic             is_load;
        logic             is_store;
        logic             is_cond_branch;
        logic             is_jump_reg;     // jirl
        logic             is_jump;         // b and bl
        logic             branch_on_eq;
        logic             gr_we;
        logic [4:0]       dest;
        logic [4:0]       raddr2;          // rk, or rd for stores and branches.
    } ctrl_t;

    // One register write event.
    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
    } trace_t;

endpackage

`default_nettype wire

// File: logic/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ========================================
// Core constants
// ========================================

// Address of the first instruction fetched after reset.
`define CPU_RESET_PC 32'h1c00_0000

// Number of architectural general registers.
`define CPU_NUM_REGS 32

`define CPU_LINK_REG 5'd1  // Register written by bl.

`endif

// File: logic/inst_decoder.sv
`default_nettype none

`include "cpu_defines.svh"

module inst_decoder (
    input  isa_pkg::inst_t  inst,
    output core_pkg::ctrl_t ctrl,
    output logic [31:0]     imm,
    output logic [31:0]     br_offs,
    output logic [31:0]     jirl_offs
);

    logic        op_zero;
    logic        reg3_grp;
    logic        shift_grp;
    logic [15:0] offs16;
    logic [25:0] offs26;

    assign op_zero   = (inst.r3.op_31_26 == 6'h00);
    assign reg3_grp  = op_zero && (inst.r3.op_25_22 == 4'h0) && (inst.r3.op_21_20 == 2'h1);
    assign shift_grp = op_zero && (inst.r3.op_25_22 == 4'h1) && (inst.r3.op_21_20 == 2'h0);
    assign offs16    = inst.ri16.offs16;
    assign offs26    = {inst.i26.offs_hi, inst.i26.offs_lo};

    // ========================================
    // Opcode match
    // ========================================

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = isa_pkg::alu_add;
        ctrl.dest   = inst.r3.rd;
        ctrl.raddr2 = inst.r3.rk;
        imm         = {{20{inst.ri12.si12[11]}}, inst.ri12.si12};
        if (reg3_grp) begin
            ctrl.gr_we = 1'b1;
            case (inst.r3.op_19_15)
                5'h00:   ctrl.alu_op = isa_pkg::alu_add;
                5'h02:   ctrl.alu_op = isa_pkg::alu_sub;
                5'h04:   ctrl.alu_op = isa_pkg::alu_slt;
                5'h05:   ctrl.alu_op = isa_pkg::alu_sltu;
                5'h08:   ctrl.alu_op = isa_pkg::alu_nor;
                5'h09:   ctrl.alu_op = isa_pkg::alu_and;
                5'h0a:   ctrl.alu_op = isa_pkg::alu_or;
                5'h0b:   ctrl.alu_op = isa_pkg::alu_xor;
                default: ctrl.gr_we  = 1'b0;
            endcase
        end else if (shift_grp) begin
            ctrl.gr_we       = 1'b1;
            ctrl.src2_is_imm = 1'b1;
            imm              = {27'd0, inst.r3.rk};  // The rk slot holds ui5 here.
            case (inst.r3.op_19_15)
                5'h01:   ctrl.alu_op = isa_pkg::alu_sll;
                5'h09:   ctrl.alu_op = isa_pkg::alu_srl;
                5'h11:   ctrl.alu_op = isa_pkg::alu_sra;
                default: ctrl.gr_we  = 1'b0;
            endcase
        end else if (op_zero && (inst.r3.op_25_22 == 4'ha)) begin
            ctrl.gr_we       = 1'b1;  // addi.w
            ctrl.src2_is_imm = 1'b1;
        end else if (inst.ri20.op_31_25 == 7'b0001010) begin
            ctrl.gr_we       = 1'b1;  // lu12i.w
            ctrl.src2_is_imm = 1'b1;
            ctrl.alu_op      = isa_pkg::alu_lui;
            imm              = {inst.ri20.si20, 12'd0};
        end else if ((inst.r3.op_31_26 == 6'h0a) && (inst.r3.op_25_22 == 4'h2)) begin
            ctrl.gr_we       = 1'b1;  // ld.w
            ctrl.src2_is_imm = 1'b1;
            ctrl.is_load     = 1'b1;
        end else if ((inst.r3.op_31_26 == 6'h0a) && (inst.r3.op_25_22 == 4'h6)) begin
            ctrl.src2_is_imm = 1'b1;  // st.w
            ctrl.is_store    = 1'b1;
            ctrl.raddr2      = inst.r3.rd;
        end else begin
            case (inst.r3.op_31_26)
                6'h13: begin
                    ctrl.is_jump_reg = 1'b1;
                    ctrl.gr_we       = 1'b1;
                    ctrl.src1_is_pc  = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    imm              = 32'd4;
                end
                6'h14: ctrl.is_jump = 1'b1;
                6'h15: begin
                    ctrl.is_jump     = 1'b1;
                    ctrl.gr_we       = 1'b1;
                    ctrl.src1_is_pc  = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.dest        = `CPU_LINK_REG;
                    imm              = 32'd4;
                end
                6'h16, 6'h17: begin
                    ctrl.is_cond_branch = 1'b1;
                    ctrl.branch_on_eq   = ~inst.r3.op_31_26[0];  // beq is even, bne odd.
                    ctrl.raddr2         = inst.r3.rd;
                end
                default: ctrl.gr_we = 1'b0;
            endcase
        end
    end

    // Branch offsets are word offsets.
    assign br_offs   = ctrl.is_jump ? {{4{offs26[25]}}, offs26, 2'b00}
                                    : {{14{offs16[15]}}, offs16, 2'b00};
    assign jirl_offs = {{14{offs16[15]}}, offs16, 2'b00};

    always_comb begin
        a_one_class: assert ($onehot0({ctrl.is_load, ctrl.is_store, ctrl.is_cond_branch,
                                       ctrl.is_jump_reg, ctrl.is_jump}));
    end

endmodule

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // ALU operations.
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_e;

    // ========================================
    // Instruction formats
    // ========================================

    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        logic [4:0] rk;  // Also the ui5 shift amount.
        logic [4:0] rj;
        logic [4:0] rd;
    } fmt_r3_t;

    typedef struct packed {
        logic [9:0]  op_31_22;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri12_t;

    typedef struct packed {
        logic [6:0]  op_31_25;
        logic [19:0] si20;
        logic [4:0]  rd;
    } fmt_ri20_t;

    typedef struct packed {
        logic [5:0]  op_31_26;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri16_t;

    // The 26-bit offset is split, with the high part in the low bits.
    typedef struct packed {
        logic [5:0]  op_31_26;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_r3_t   r3;
        fmt_ri12_t ri12;
        fmt_ri20_t ri20;
        fmt_ri16_t ri16;
        fmt_i26_t  i26;
    } inst_t;

endpackage

`default_nettype wire

// File: logic/mycpu_top.sv
`default_nettype none

`include "cpu_defines.svh"

module mycpu_top (
    input  logic             clk,
    input  logic             reset,
    output logic [31:0]      inst_sram_addr,
    input  logic [31:0]      inst_sram_rdata,
    output logic             data_sram_en,
    output logic             data_sram_we,
    output logic [31:0]      data_sram_addr,
    output logic [31:0]      data_sram_wdata,
    input  logic [31:0]      data_sram_rdata,
    output core_pkg::trace_t debug_wb
);

    core_pkg::state_e state;
    core_pkg::state_e state_next;

    logic [31:0]     pc;
    logic [31:0]     next_pc;
    logic [31:0]     next_pc_q;
    isa_pkg::inst_t  inst;
    isa_pkg::inst_t  inst_q;
    core_pkg::ctrl_t ctrl;
    core_pkg::ctrl_t ctrl_q;
    logic [31:0]     imm;
    logic [31:0]     br_offs;
    logic [31:0]     jirl_offs;

    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic        rj_eq_rd;
    logic [31:0] src1_q;
    logic [31:0] src2_q;
    logic [31:0] rkd_q;
    logic [31:0] alu_result;
    logic [31:0] alu_result_q;
    logic        rf_we;
    logic [31:0] rf_wdata;

    // ========================================
    // Fetch and decode
    // ========================================

    assign inst_sram_addr = pc;

    // The SRAM word is live in s_id; later states see the latched copy.
    assign inst = (state == core_pkg::s_id) ? inst_sram_rdata : inst_q;

    inst_decoder u_inst_decoder (
        .inst      (inst),
        .ctrl      (ctrl),
        .imm       (imm),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (inst.r3.rj),
        .rdata1 (rj_value),
        .raddr2 (ctrl.raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (ctrl_q.dest),
        .wdata  (rf_wdata)
    );

    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        next_pc = pc + 32'd4;
        if (ctrl.is_jump) begin
            next_pc = pc + br_offs;
        end else if (ctrl.is_jump_reg) begin
            next_pc = rj_value + jirl_offs;
        end else if (ctrl.is_cond_branch && (rj_eq_rd == ctrl.branch_on_eq)) begin
            next_pc = pc + br_offs;
        end
    end

    // ========================================
    // State machine and PC
    // ========================================

    always_comb begin
        case (state)
            core_pkg::s_if:  state_next = core_pkg::s_id;
            core_pkg::s_id:  begin
                // b, beq, bne and unknown words finish here.
                state_next = (ctrl.gr_we || ctrl.is_store) ? core_pkg::s_exe : core_pkg::s_if;
            end
            core_pkg::s_exe: begin
                state_next = (ctrl_q.is_load || ctrl_q.is_store) ? core_pkg::s_mem
                                                                 : core_pkg::s_wb;
            end
            core_pkg::s_mem: state_next = ctrl_q.is_load ? core_pkg::s_wb : core_pkg::s_if;
            default:         state_next = core_pkg::s_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::s_if;
            pc    <= `CPU_RESET_PC;
        end else begin
            state <= state_next;
            if (state_next == core_pkg::s_if) begin
                pc <= (state == core_pkg::s_id) ? next_pc : next_pc_q;  // Last cycle.
            end
        end
    end

    // Operand and result latches.
    always_ff @(posedge clk) begin
        if (state == core_pkg::s_id) begin
            inst_q    <= inst_sram_rdata;
            ctrl_q    <= ctrl;
            next_pc_q <= next_pc;
            src1_q    <= ctrl.src1_is_pc ? pc : rj_value;
            src2_q    <= ctrl.src2_is_imm ? imm : rkd_value;
            rkd_q     <= rkd_value;
        end
        if (state == core_pkg::s_exe) begin
            alu_result_q <= alu_result;
        end
    end

    alu u_alu (
        .alu_op (ctrl_q.alu_op),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    // ========================================
    // Memory and writeback
    // ========================================

    assign data_sram_en    = (state == core_pkg::s_mem) && (ctrl_q.is_load || ctrl_q.is_store);
    assign data_sram_we    = (state == core_pkg::s_mem) && ctrl_q.is_store;
    assign data_sram_addr  = alu_result_q;
    assign data_sram_wdata = rkd_q;

    assign rf_we    = (state == core_pkg::s_wb) && ctrl_q.gr_we && (ctrl_q.dest != 5'd0);
    assign rf_wdata = ctrl_q.is_load ? data_sram_rdata : alu_result_q;  // Load data is live.

    assign debug_wb = '{pc: pc, rf_we: rf_we, rf_wnum: ctrl_q.dest, rf_wdata: rf_wdata};

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {core_pkg::s_if, core_pkg::s_id, core_pkg::s_exe,
                      core_pkg::s_mem, core_pkg::s_wb});

    // A store is the last step of its instruction.
    a_store_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> (state == core_pkg::s_mem) ##1 (state == core_pkg::s_if));

    a_trace_in_wb: assert property (@(posedge clk) disable iff (reset)
        debug_wb.rf_we |-> (state == core_pkg::s_wb) ##1 (state == core_pkg::s_if));

endmodule

`default_nettype wire

// File: logic/regfile.sv
`default_nettype none

`include "cpu_defines.svh"

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
        regs[0] <= 32'd0;  // Entry 0 is cleared on every clock.
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    a_r0_zero: assert property (@(posedge clk) (raddr1 == 5'd0) |-> (rdata1 == 32'd0));

endmodule

`default_nettype wire
